// ==== bench/tb_axi_mem.sv ====
// --------------------------------------
// AXI write slave model, 64 KB word memory
// INCR bursts of full width only, W may lead AW
// one burst index can be answered with SLVERR
// --------------------------------------

`timescale 1ns/1ps

module tb_axi_mem
	import dma_pkg::*;
(
	input  logic              aclk,
	input  logic              aresetn,
	input  logic              rand_ready,
	input  int                err_burst,
	input  axi_aw_t           aw,
	input  logic              aw_valid,
	output logic              aw_ready,
	input  axi_w_t            w,
	input  logic              w_valid,
	output logic              w_ready,
	output axi_b_t            b,
	output logic              b_valid,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [DATA_W-1:0] rd_data,
	output axi_aw_t           log_aw,
	output logic              log_valid
);

	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic [DATA_W-1:0] mem [0:16383];
	axi_aw_t           aw_q[$];
	axi_w_t            w_q[$];
	logic [1:0]        resp_q[$];
	axi_w_t            beat;
	logic [13:0]       idx;
	int                beat_idx;
	int                burst_num;

	// untouched words read back as the inverted byte address
	initial begin
		for (int i = 0; i < 16384; i++) begin
			mem[i] = ~(ADDR_W'(i) << DATA_SIZE);
		end
	end

	assign rd_data = mem[rd_addr[15:2]];

	// --------------------------------------
	// accept, write and log
	// --------------------------------------
	always @(posedge aclk) begin
		log_valid <= 1'b0;
		if (!aresetn) begin
			aw_q.delete();
			w_q.delete();
			resp_q.delete();
			beat_idx = 0;
			burst_num = 0;
		end else begin
			if (aw_valid && aw_ready)
				aw_q.push_back(aw);
			if (w_valid && w_ready)
				w_q.push_back(w);
			// one beat per cycle into the oldest open burst
			if (aw_q.size() != 0 && w_q.size() != 0) begin
				beat = w_q.pop_front();
				idx = aw_q[0].addr[15:2] + 14'(beat_idx);
				mem[idx] = beat.data;
				if (beat_idx == int'(aw_q[0].len)) begin
					resp_q.push_back((burst_num == err_burst) ? RESP_SLVERR : RESP_OKAY);
					log_aw <= aw_q.pop_front();
					log_valid <= 1'b1;
					burst_num++;
					beat_idx = 0;
				end else begin
					beat_idx++;
				end
			end
		end
	end

	// ready and response driving
	initial begin
		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		b = '0;
		forever begin
			@(negedge aclk);
			aw_ready = !rand_ready || ($urandom_range(1) == 0);
			w_ready = !rand_ready || ($urandom_range(3) != 0);
			b_valid = 1'b0;
			if (resp_q.size() != 0 && (!rand_ready || $urandom_range(1) == 0)) begin
				b.resp = resp_q.pop_front();
				b_valid = 1'b1;
			end
		end
	end

endmodule

// ==== bench/tb_dma_writer.sv ====
// --------------------------------------
// testbench for the stream-to-memory write DMA
// addresses stay inside the 64 KB slave window
// stream words count up across all transfers
// --------------------------------------

`timescale 1ns/1ps

module tb_dma_writer
	import dma_pkg::*;
();

	localparam logic [DATA_W-1:0] DATA_SEED = 32'h1000_0000;
	localparam int TOTAL_BEATS = 476;
	localparam int WATCHDOG_CYCLES = (TOTAL_BEATS + 100) * 40;

	logic aclk = 1'b0;
	logic aresetn, enable, busy, error;
	logic aw_valid, aw_ready, w_valid, w_ready, b_valid, s_tvalid, s_tready, rand_ready;
	logic log_valid;
	dma_param_t param;
	axi_aw_t aw, log_aw;
	axi_w_t w;
	axi_b_t b;
	logic [DATA_W-1:0] s_tdata, next_data, stream_end, rd_data;
	logic [ADDR_W-1:0] rd_addr;
	int err_burst;
	int errors = 0;
	int checks = 0;
	int b_seen = 0;
	int bursts_total = 0;
	axi_aw_t exp_aw[$];
	axi_w_t exp_w[$];

	always #10 aclk = ~aclk;

	dma_writer_top dut (
		.aclk(aclk), .aresetn(aresetn), .enable(enable), .param(param),
		.busy(busy), .error(error), .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready), .b(b), .b_valid(b_valid),
		.s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready)
	);

	tb_axi_mem mem (
		.aclk(aclk), .aresetn(aresetn), .rand_ready(rand_ready), .err_burst(err_burst),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready), .w(w), .w_valid(w_valid),
		.w_ready(w_ready), .b(b), .b_valid(b_valid), .rd_addr(rd_addr), .rd_data(rd_data),
		.log_aw(log_aw), .log_valid(log_valid)
	);

	// --------------------------------------
	// reference model
	// --------------------------------------
	// queues the expected bursts and W beats, returns the burst count
	function automatic int plan_transfer(input dma_param_t p, input logic [DATA_W-1:0] base);
		longint addr;
		longint left;
		longint n;
		longint room;
		int bursts;
		axi_aw_t e;
		axi_w_t wb;
		addr = p.addr;
		left = p.count;
		bursts = 0;
		wb.strb = '1;
		wb.data = base;
		while (left > 0) begin
			n = longint'(p.maxlen) + 1;
			if (left < n)
				n = left;
			room = (BOUNDARY_BYTES - (addr % BOUNDARY_BYTES)) / (1 << DATA_SIZE);
			if (room < n)
				n = room;
			e.addr = ADDR_W'(addr);
			e.len = LEN_W'(n - 1);
			exp_aw.push_back(e);
			for (longint i = 0; i < n; i++) begin
				wb.last = (i == n - 1);
				exp_w.push_back(wb);
				wb.data = wb.data + 1;
			end
			addr = addr + n * (1 << DATA_SIZE);
			left = left - n;
			bursts++;
		end
		return bursts;
	endfunction

	task automatic check_aw(input axi_aw_t got, input axi_aw_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED aw: got addr %h len %h, expected addr %h len %h",
				got.addr, got.len, exp.addr, exp.len);
		end
	endtask

	task automatic check_w(input axi_w_t got, input axi_w_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED w: got data %h strb %h last %h, expected %h %h %h",
				got.data, got.strb, got.last, exp.data, exp.strb, exp.last);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED mem[%h]: got %h, expected %h", a, got, exp);
		end
	endtask

	// --------------------------------------
	// stream source and compare
	// --------------------------------------
	always @(posedge aclk) begin
		if (!aresetn)
			next_data <= DATA_SEED;
		else if (s_tvalid && s_tready)
			next_data <= next_data + 1;
	end

	// a valid word is held until taken
	initial begin
		s_tvalid = 1'b0;
		s_tdata = '0;
		forever begin
			@(negedge aclk);
			if (!(s_tvalid && s_tdata == next_data)) begin
				s_tdata = next_data;
				s_tvalid = (next_data != stream_end) && (!rand_ready || $urandom_range(3) != 0);
			end
		end
	end

	always @(posedge aclk) begin
		if (aresetn) begin
			if (w_valid && w_ready) begin
				if (exp_w.size() == 0) begin
					errors++;
					$display("W beat with data %h arrived when none was expected", w.data);
				end else begin
					check_w(w, exp_w.pop_front());
				end
			end
			if (log_valid) begin
				if (exp_aw.size() == 0) begin
					errors++;
					$display("burst at %h arrived when none was expected", log_aw.addr);
				end else begin
					check_aw(log_aw, exp_aw.pop_front());
				end
			end
			if (b_valid)
				b_seen++;
		end
	end

	// words of the transfer, and the untouched fill just outside it
	task automatic check_memory(input dma_param_t p, input logic [DATA_W-1:0] base);
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] exp;
		for (int i = -1; i <= int'(p.count); i++) begin
			a = p.addr + ADDR_W'(i * 4);
			if (i < 0 || i == int'(p.count))
				exp = ~a;
			else
				exp = base + DATA_W'(i);
			rd_addr = a;
			#1;
			check_word(a, rd_data, exp);
		end
		@(negedge aclk);
	endtask

	task automatic run_transfer(input logic [ADDR_W-1:0] addr, input int count,
			input int maxlen, input logic rnd, input int bad, input logic exp_err);
		dma_param_t p;
		logic [DATA_W-1:0] base;
		int n;
		p.addr = addr;
		p.count = COUNT_W'(count);
		p.maxlen = LEN_W'(maxlen);
		base = next_data;
		n = plan_transfer(p, base);
		err_burst = (bad < 0) ? -1 : bursts_total + bad;
		rand_ready = rnd;
		stream_end = base + DATA_W'(count);
		param = p;
		enable = 1'b1;
		@(negedge aclk);
		enable = 1'b0;
		check_flag("busy", busy, 1'b1);
		while (busy)
			@(negedge aclk);
		bursts_total += n;
		if (b_seen != bursts_total || exp_aw.size() != 0 || exp_w.size() != 0) begin
			errors++;
			$display("busy fell with %0d responses, %0d bursts and %0d beats missing",
				bursts_total - b_seen, exp_aw.size(), exp_w.size());
		end
		check_flag("error", error, exp_err);
		check_memory(p, base);
	endtask

	// --------------------------------------
	// test sequence and watchdog
	// --------------------------------------
	initial begin
		void'($urandom(32'h6606));
		aresetn = 1'b0;
		enable = 1'b0;
		param = '0;
		rand_ready = 1'b0;
		err_burst = -1;
		rd_addr = '0;
		stream_end = DATA_SEED;
		repeat (4) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;
		@(negedge aclk);
		run_transfer(32'h0000_0100, 6, 15, 1'b0, -1, 1'b0);
		run_transfer(32'h0000_1000, 100, 7, 1'b0, -1, 1'b0);
		// four beats left before the 4 KB page ends
		run_transfer(32'h0000_2ff0, 20, 15, 1'b0, -1, 1'b0);
		run_transfer(32'h0000_5e80, 300, 31, 1'b1, -1, 1'b0);
		run_transfer(32'h0000_8000, 40, 7, 1'b1, 2, 1'b1);
		run_transfer(32'h0000_9000, 10, 3, 1'b1, -1, 1'b0);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge aclk);
		$display("timeout after %0d cycles, checks: %0d, errors: %0d",
			WATCHDOG_CYCLES, checks, errors);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the write DMA testbench with Verilator and run it.
# Passes only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_dma_writer --Mdir obj_dir -o tb_dma_writer
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_dma_writer)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// ==== sim.f ====
verilog/dma_pkg.sv
verilog/dma_burst_addr.sv
verilog/dma_stream_writer.sv
verilog/dma_write_resp.sv
verilog/dma_writer_top.sv
bench/tb_axi_mem.sv
bench/tb_dma_writer.sv

// ==== verilog/dma_burst_addr.sv ====
// --------------------------------------
// burst splitter for the write DMA
// start is only honoured while idle
// one burst is offered to AW and to the W side
// at a time, each released on its own handshake
// --------------------------------------

`timescale 1ns/1ps

module dma_burst_addr
	import dma_pkg::*;
(
	input  logic             aclk,
	input  logic             aresetn,
	input  logic             start,
	input  dma_param_t       param,
	output logic             busy,
	output axi_aw_t          aw,
	output logic             aw_valid,
	input  logic             aw_ready,
	output logic [LEN_W-1:0] cmd_len,
	output logic             cmd_valid,
	input  logic             cmd_ready
);

	logic [ADDR_W-1:0]  addr_r;
	logic [COUNT_W-1:0] remain_r;
	logic [LEN_W-1:0]   maxlen_r;

	logic [ADDR_W-1:0]  off_bytes;
	logic [COUNT_W-1:0] max_beats;
	logic [COUNT_W-1:0] bound_beats;
	logic [COUNT_W-1:0] burst_beats;
	logic [LEN_W-1:0]   burst_len;
	logic               aw_free;
	logic               cmd_free;
	logic               issue;
	logic               last_gone;

	// --------------------------------------
	// burst length
	// --------------------------------------
	always_comb begin
		// offset of the current address inside its 4 KB page
		off_bytes   = ADDR_W'(addr_r[$clog2(BOUNDARY_BYTES)-1:0]);
		max_beats   = COUNT_W'(maxlen_r) + COUNT_W'(1);
		bound_beats = COUNT_W'((ADDR_W'(BOUNDARY_BYTES) - off_bytes) >> DATA_SIZE);
		burst_beats = max_beats;
		if (remain_r < burst_beats) begin
			burst_beats = remain_r;
		end
		if (bound_beats < burst_beats) begin
			burst_beats = bound_beats;
		end
		burst_len = LEN_W'(burst_beats - COUNT_W'(1));
	end

	// a slot is free when empty or emptying this cycle
	assign aw_free   = !aw_valid || aw_ready;
	assign cmd_free  = !cmd_valid || cmd_ready;
	assign issue     = busy && (remain_r != '0) && aw_free && cmd_free;
	assign last_gone = busy && (remain_r == '0) && aw_free && cmd_free;

	// --------------------------------------
	// control
	// --------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy      <= 1'b0;
			aw_valid  <= 1'b0;
			cmd_valid <= 1'b0;
			remain_r  <= '0;
		end else begin
			if (start) begin
				busy <= 1'b1;
			end else if (last_gone) begin
				busy <= 1'b0;
			end

			if (issue) begin
				aw_valid <= 1'b1;
			end else if (aw_ready) begin
				aw_valid <= 1'b0;
			end

			if (issue) begin
				cmd_valid <= 1'b1;
			end else if (cmd_ready) begin
				cmd_valid <= 1'b0;
			end

			if (start) begin
				remain_r <= param.count;
			end else if (issue) begin
				remain_r <= remain_r - burst_beats;
			end
		end
	end

	// address and burst payload
	always_ff @(posedge aclk) begin
		if (start) begin
			addr_r   <= param.addr;
			maxlen_r <= param.maxlen;
		end else if (issue) begin
			addr_r <= addr_r + (ADDR_W'(burst_beats) << DATA_SIZE);
		end

		if (issue) begin
			aw.addr <= addr_r;
			aw.len  <= burst_len;
			cmd_len <= burst_len;
		end
	end

	// --------------------------------------
	// checks
	// --------------------------------------
	a_aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw));

	// last byte of every burst stays inside the page it starts in
	a_aw_no_cross: assert property (@(posedge aclk) disable iff (!aresetn)
		aw_valid |-> ADDR_W'(aw.addr[$clog2(BOUNDARY_BYTES)-1:0])
			+ ((ADDR_W'(aw.len) + 1) << DATA_SIZE) <= ADDR_W'(BOUNDARY_BYTES));

endmodule

// ==== verilog/dma_pkg.sv ====
// --------------------------------------
// shared widths, limits and channel structs
// for the stream-to-memory write DMA
// beats are always full width, INCR bursts only
// --------------------------------------

package dma_pkg;

	// --------------------------------------
	// widths
	// --------------------------------------
	localparam int ADDR_W    = 32;
	// log2 of bytes per beat
	localparam int DATA_SIZE = 2;
	localparam int DATA_W    = 32;
	localparam int STRB_W    = 4;
	localparam int LEN_W     = 8;
	localparam int COUNT_W   = ADDR_W - DATA_SIZE;

	// bursts never straddle this
	localparam int BOUNDARY_BYTES = 4096;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// --------------------------------------
	// structs
	// --------------------------------------
	// addr must be beat aligned, count at least one,
	// maxlen in AXI encoding (beats minus one)
	typedef struct packed {
		logic [ADDR_W-1:0]  addr;
		logic [COUNT_W-1:0] count;
		logic [LEN_W-1:0]   maxlen;
	} dma_param_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
	} axi_aw_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

endpackage

// ==== verilog/dma_stream_writer.sv ====
// --------------------------------------
// stream to AXI W path with its burst generator
// stream data goes straight to wdata, all strobes set
// a new command is taken only when no burst is open
// --------------------------------------

`timescale 1ns/1ps

module dma_stream_writer
	import dma_pkg::*;
(
	input  logic              aclk,
	input  logic              aresetn,
	input  logic              start,
	input  dma_param_t        param,
	output logic              busy,
	output axi_aw_t           aw,
	output logic              aw_valid,
	input  logic              aw_ready,
	output axi_w_t            w,
	output logic              w_valid,
	input  logic              w_ready,
	input  logic [DATA_W-1:0] s_tdata,
	input  logic              s_tvalid,
	output logic              s_tready
);

	logic             addr_busy;
	logic [LEN_W-1:0] cmd_len;
	logic             cmd_valid;
	logic             cmd_ready;

	// open burst state
	logic             open_r;
	logic [LEN_W-1:0] cnt_r;
	logic [LEN_W-1:0] cur_cnt;
	logic             held;
	logic             beat;

	// commands taken whose wlast beat has not gone yet
	logic [1:0]       cmds_open;

	dma_burst_addr u_burst_addr (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.start     (start),
		.param     (param),
		.busy      (addr_busy),
		.aw        (aw),
		.aw_valid  (aw_valid),
		.aw_ready  (aw_ready),
		.cmd_len   (cmd_len),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready)
	);

	// --------------------------------------
	// W beat path
	// --------------------------------------
	assign cmd_ready = !open_r;

	// an offered command counts as held, so the first beat
	// can go out in the same cycle the command is taken
	assign held    = open_r || cmd_valid;
	assign cur_cnt = open_r ? cnt_r : cmd_len;

	assign w.data   = s_tdata;
	assign w.strb   = '1;
	assign w.last   = (cur_cnt == '0);
	assign w_valid  = held && s_tvalid;
	assign s_tready = held && w_ready;

	assign beat = w_valid && w_ready;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			open_r <= 1'b0;
		end else if (beat) begin
			// single-beat burst taken and finished in one cycle stays closed
			open_r <= !w.last;
		end else if (cmd_valid && cmd_ready) begin
			open_r <= 1'b1;
		end
	end

	// beats left after the current one
	always_ff @(posedge aclk) begin
		if (beat) begin
			cnt_r <= cur_cnt - 1'b1;
		end else if (cmd_valid && cmd_ready) begin
			cnt_r <= cmd_len;
		end
	end

	assign busy = addr_busy || open_r;

	// --------------------------------------
	// checks
	// --------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			cmds_open <= '0;
		end else begin
			case ({cmd_valid && cmd_ready, beat && w.last})
				2'b10:   cmds_open <= cmds_open + 1'b1;
				2'b01:   cmds_open <= cmds_open - 1'b1;
				default: cmds_open <= cmds_open;
			endcase
		end
	end

	// W valid only inside a taken or offered command
	a_w_has_cmd: assert property (@(posedge aclk) disable iff (!aresetn)
		w_valid |-> (cmds_open != '0) || cmd_valid);

endmodule

// ==== verilog/dma_write_resp.sv ====
// --------------------------------------
// write response tracker
// the engine takes a B response every cycle
// error is sticky until the next start
// --------------------------------------

`timescale 1ns/1ps

module dma_write_resp
	import dma_pkg::*;
(
	input  logic   aclk,
	input  logic   aresetn,
	input  logic   start,
	input  logic   aw_fire,
	input  axi_b_t b,
	input  logic   b_valid,
	output logic   pending,
	output logic   error
);

	// bursts sent on AW whose response is still out
	logic [COUNT_W-1:0] outstanding;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			outstanding <= '0;
		end else begin
			case ({aw_fire, b_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	assign pending = (outstanding != '0);

	// --------------------------------------
	// sticky error
	// --------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			error <= 1'b0;
		end else if (start) begin
			error <= 1'b0;
		end else if (b_valid && b.resp != RESP_OKAY) begin
			error <= 1'b1;
		end
	end

	// --------------------------------------
	// checks
	// --------------------------------------
	// a response always follows its AW handshake
	a_b_has_aw: assert property (@(posedge aclk) disable iff (!aresetn)
		b_valid |-> outstanding != '0);

endmodule

// ==== verilog/dma_writer_top.sv ====
// --------------------------------------
// write DMA top level
// enable starts a transfer whenever idle
// busy covers the last B response
// --------------------------------------

`timescale 1ns/1ps

module dma_writer_top
	import dma_pkg::*;
(
	input  logic              aclk,
	input  logic              aresetn,
	input  logic              enable,
	input  dma_param_t        param,
	output logic              busy,
	output logic              error,
	output axi_aw_t           aw,
	output logic              aw_valid,
	input  logic              aw_ready,
	output axi_w_t            w,
	output logic              w_valid,
	input  logic              w_ready,
	input  axi_b_t            b,
	input  logic              b_valid,
	input  logic [DATA_W-1:0] s_tdata,
	input  logic              s_tvalid,
	output logic              s_tready
);

	logic start;
	logic aw_fire;
	logic wr_busy;
	logic pending;

	assign start   = enable && !busy;
	assign aw_fire = aw_valid && aw_ready;
	assign busy    = wr_busy || pending;

	dma_stream_writer u_writer (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.start    (start),
		.param    (param),
		.busy     (wr_busy),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.s_tdata  (s_tdata),
		.s_tvalid (s_tvalid),
		.s_tready (s_tready)
	);

	dma_write_resp u_resp (
		.aclk    (aclk),
		.aresetn (aresetn),
		.start   (start),
		.aw_fire (aw_fire),
		.b       (b),
		.b_valid (b_valid),
		.pending (pending),
		.error   (error)
	);

endmodule
